/* Makefile */
# Verilator build for the CPU trace UART testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_trace_uart
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Test passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the simulator exit code
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS: found pass message in $(LOG)"; \
	else \
		echo "FAIL: pass message missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* char_fifo.sv */
`timescale 1ns/10ps

module char_fifo import trace_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr,
	input  rec_word_u  wdata,
	input  logic       rd,
	output logic [7:0] rdata,
	output logic       empty
);

	logic [WORD_BITS-1:0] mem [FIFO_WORDS];

	// Extra pointer bit tells full from empty
	logic [FIFO_PTR_W:0] wr_ptr;
	logic [FIFO_PTR_W:0] rd_ptr;
	logic [CHAR_IDX_W-1:0] char_idx;
	logic [CHAR_IDX_W-1:0] char_sel;
	logic [WORD_BITS-1:0] head;

	assign empty = (wr_ptr == rd_ptr);

	////////////////////////////////////////////////////////////////////////////
	// Head character, no read latency
	////////////////////////////////////////////////////////////////////////////

	assign head = mem[rd_ptr[FIFO_PTR_W-1:0]];

	// Index 0 is the first character out, the top byte of the word
	assign char_sel = CHAR_IDX_W'(CHARS_PER_WORD - 1) - char_idx;
	assign rdata = head[char_sel*8 +: 8];

	////////////////////////////////////////////////////////////////////////////
	// Storage and pointers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_ptr[FIFO_PTR_W-1:0]] <= wdata.flat;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (wr) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr <= '0;
			char_idx <= '0;
		end else if (rd && !empty) begin
			if (char_idx == CHAR_IDX_W'(CHARS_PER_WORD - 1)) begin
				// Last character of the word, move to the next one
				char_idx <= '0;
				rd_ptr <= rd_ptr + 1'b1;
			end else begin
				char_idx <= char_idx + 1'b1;
			end
		end
	end

endmodule

/* cpu_trace_uart.sv */
`timescale 1ns/10ps

module cpu_trace_uart import trace_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  cpu_trace_t trace,
	output logic       halt,
	output logic       txd
);

	logic step;
	rec_field_e fld;
	logic fifo_wr;
	logic fifo_rd;
	logic trmt;
	rec_word_u word;
	logic [7:0] tx_byte;
	logic empty;
	logic tbr;

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////

	trace_ctrl ctrl (
		.clk     (clk),
		.rst     (rst),
		.empty   (empty),
		.tbr     (tbr),
		.halt    (halt),
		.step    (step),
		.fld     (fld),
		.fifo_wr (fifo_wr),
		.fifo_rd (fifo_rd),
		.trmt    (trmt)
	);

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	trace_packer packer (
		.clk   (clk),
		.rst   (rst),
		.step  (step),
		.trace (trace),
		.fld   (fld),
		.word  (word)
	);

	char_fifo fifo (
		.clk   (clk),
		.rst   (rst),
		.wr    (fifo_wr),
		.wdata (word),
		.rd    (fifo_rd),
		.rdata (tx_byte),
		.empty (empty)
	);

	uart_tx tx (
		.clk     (clk),
		.rst     (rst),
		.trmt    (trmt),
		.tx_byte (tx_byte),
		.tbr     (tbr),
		.txd     (txd)
	);

endmodule

/* src.f */
trace_pkg.sv
trace_ctrl.sv
trace_packer.sv
char_fifo.sv
uart_tx.sv
cpu_trace_uart.sv
tb_cpu_trace_uart.sv

/* tb_cpu_trace_uart.sv */
`timescale 1ns/10ps

module tb_cpu_trace_uart import trace_pkg::*; ();

	localparam int NUM_RECORDS = 12;
	localparam int LINE_CHARS = 32;
	// 12 records x 32 frames x 10 bits x 16 cycles is 61,440, rounded up for gaps
	localparam int TIMEOUT_CYCLES = 70_000;
	localparam logic [31:0] LFSR_SEED = 32'h7f9f_e28c;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [127:0] HEX_DIGITS = "0123456789ABCDEF";

	logic clk = 1'b0;
	logic rst = 1'b1;
	cpu_trace_t trace = '0;
	logic halt;
	logic txd;

	logic [31:0] lfsr_state = LFSR_SEED;
	cpu_trace_t rec_q[$];
	logic [8*LINE_CHARS-1:0] rx_lines[$];
	int steps = 0;
	int chars_started = 0;
	int lines_checked = 0;
	int cycles = 0;
	logic halt_was_low = 1'b0;

	int step_errs = 0;
	int frame_errs = 0;
	int content_errs = 0;
	int run_errs = 0;

	cpu_trace_uart dut (
		.clk   (clk),
		.rst   (rst),
		.trace (trace),
		.halt  (halt),
		.txd   (txd)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Records 0 and 1 are fixed, the rest come from the LFSR
	task automatic make_record(input int n, output cpu_trace_t r);
		logic [31:0] bits;
		if (n == 0) begin
			r = '0;
		end else if (n == 1) begin
			r = '1;
		end else begin
			draw_bits(32, bits);
			r.instr = bits;
			draw_bits(32, bits);
			r.addr = bits;
			draw_bits(32, bits);
			r.wdata = bits;
			draw_bits(1, bits);
			r.wr = bits[0];
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference line
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] hex_digit(input logic [3:0] nib);
		int idx;
		idx = int'(nib);
		return HEX_DIGITS[8*(15 - idx) +: 8];
	endfunction

	// Character 0 sits in the top byte
	function automatic logic [8*LINE_CHARS-1:0] format_line(input cpu_trace_t r);
		logic [8*LINE_CHARS-1:0] line;
		logic [95:0] fields;
		fields = {r.instr, r.addr, r.wdata};
		line = '0;
		for (int k = 0; k < 24; k++) begin
			line[8*LINE_CHARS-1 - 8*k -: 8] = hex_digit(fields[95 - 4*k -: 4]);
		end
		for (int k = 24; k < 29; k++) begin
			line[8*LINE_CHARS-1 - 8*k -: 8] = 8'h20;
		end
		line[8*LINE_CHARS-1 - 8*29 -: 8] = r.wr ? 8'h31 : 8'h30;
		line[15:8] = ASCII_CR;
		line[7:0] = ASCII_LF;
		return line;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// CPU model and step discipline
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : cpu_model
		cpu_trace_t next_rec;
		if (rst) begin
			halt_was_low = 1'b0;
		end else if (halt === 1'b0) begin
			if (halt_was_low) begin
				step_errs++;
				$display("halt stayed low for a second cycle at step %0d", steps);
			end
			if (chars_started < LINE_CHARS * steps) begin
				step_errs++;
				$display("Step %0d came after only %0d characters had started",
					steps, chars_started);
			end
			// The DUT takes this trace on the same edge
			rec_q.push_back(trace);
			steps++;
			make_record(steps, next_rec);
			trace <= next_rec;
			halt_was_low = 1'b1;
		end else begin
			if (halt !== 1'b1) begin
				step_errs++;
				$display("halt is unknown");
			end
			halt_was_low = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// UART receiver, samples on the falling clock edge
	////////////////////////////////////////////////////////////////////////////

	initial begin : receiver
		logic [7:0] data;
		logic [8*LINE_CHARS-1:0] line;
		logic first;
		logic held;
		int nchar;
		data = '0;
		line = '0;
		nchar = 0;
		forever begin
			@(negedge clk);
			if (!rst && txd === 1'b0) begin
				chars_started++;
				held = 1'b1;
				first = 1'b0;
				for (int b = 0; b < 10; b++) begin
					for (int c = 0; c < BAUD_DIV; c++) begin
						if (b != 0 || c != 0) begin
							@(negedge clk);
						end
						if (c == 0) begin
							first = txd;
						end else if (txd !== first) begin
							held = 1'b0;
						end
						// Middle of the bit
						if (c == BAUD_DIV / 2) begin
							if (b >= 1 && b <= 8) begin
								data[b-1] = txd;
							end
							if (b == 9 && txd !== 1'b1) begin
								frame_errs++;
								$display("Framing failure, stop bit of character %0d is not high",
									chars_started);
							end
						end
					end
				end
				if (!held) begin
					frame_errs++;
					$display("Character %0d has a bit that did not hold for %0d cycles",
						chars_started, BAUD_DIV);
				end
				line[8*LINE_CHARS-1 - 8*nchar -: 8] = data;
				nchar++;
				if (nchar == LINE_CHARS) begin
					rx_lines.push_back(line);
					nchar = 0;
				end
			end else if (rst && txd !== 1'b1) begin
				frame_errs++;
				$display("txd is not high during reset");
			end else if (!rst && txd !== 1'b1) begin
				frame_errs++;
				$display("txd is unknown while the line is idle");
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Line compare
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : compare
		logic [8*LINE_CHARS-1:0] got;
		logic [8*LINE_CHARS-1:0] exp;
		cpu_trace_t rec;
		logic [7:0] e;
		logic [7:0] a;
		if (rx_lines.size() > 0) begin
			got = rx_lines.pop_front();
			if (rec_q.size() == 0) begin
				content_errs++;
				$display("Line %0d arrived with no stepped record behind it", lines_checked);
			end else begin
				rec = rec_q.pop_front();
				exp = format_line(rec);
				for (int k = 0; k < LINE_CHARS; k++) begin
					e = exp[8*LINE_CHARS-1 - 8*k -: 8];
					a = got[8*LINE_CHARS-1 - 8*k -: 8];
					if (a !== e) begin
						content_errs++;
						$display("ERR line_content line %0d char %0d: expected %02h, actual %02h",
							lines_checked, k, e, a);
					end
				end
				if (got[15:8] !== ASCII_CR || got[7:0] !== ASCII_LF) begin
					content_errs++;
					$display("Line %0d does not end in CR then LF", lines_checked);
				end
			end
			lines_checked++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reset, run length and result
	////////////////////////////////////////////////////////////////////////////

	initial begin
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (halt !== 1'b0) begin
			run_errs++;
			$display("halt is not low in the first cycle after reset");
		end
		while (lines_checked < NUM_RECORDS && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		if (lines_checked < NUM_RECORDS) begin
			run_errs++;
			$display("Timeout after %0d cycles with %0d of %0d lines received",
				cycles, lines_checked, NUM_RECORDS);
		end
		if (steps != lines_checked && steps != lines_checked + 1) begin
			run_errs++;
			$display("%0d steps taken for %0d lines received", steps, lines_checked);
		end
		$display("Errors: %0d step, %0d framing, %0d content, %0d run",
			step_errs, frame_errs, content_errs, run_errs);
		if (step_errs + frame_errs + content_errs + run_errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* trace_ctrl.sv */
`timescale 1ns/10ps

module trace_ctrl import trace_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       empty,
	input  logic       tbr,
	output logic       halt,
	output logic       step,
	output rec_field_e fld,
	output logic       fifo_wr,
	output logic       fifo_rd,
	output logic       trmt
);

	trace_state_e state;
	trace_state_e next_state;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state and outputs
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		halt = 1'b1;
		step = 1'b0;
		fld = FLD_INSTR;
		fifo_wr = 1'b0;
		fifo_rd = 1'b0;
		trmt = 1'b0;

		case (state)
			ST_IDLE: begin
				if (empty) begin
					// Let the CPU run for this one cycle
					halt = 1'b0;
					step = 1'b1;
					next_state = ST_INSTR;
				end else begin
					// Drain one character whenever the transmitter is free
					fifo_rd = tbr;
					trmt = tbr;
				end
			end
			ST_INSTR: begin
				fld = FLD_INSTR;
				fifo_wr = 1'b1;
				next_state = ST_ADDR;
			end
			ST_ADDR: begin
				fld = FLD_ADDR;
				fifo_wr = 1'b1;
				next_state = ST_DATA;
			end
			ST_DATA: begin
				fld = FLD_DATA;
				fifo_wr = 1'b1;
				next_state = ST_TAIL;
			end
			ST_TAIL: begin
				fld = FLD_TAIL;
				fifo_wr = 1'b1;
				next_state = ST_IDLE;
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

endmodule

/* trace_packer.sv */
`timescale 1ns/10ps

module trace_packer import trace_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       step,
	input  cpu_trace_t trace,
	input  rec_field_e fld,
	output rec_word_u  word
);

	cpu_trace_t snap;
	logic [31:0] field;

	// Nibble to capital hex digit
	function automatic logic [7:0] hex_char(input logic [3:0] nib);
		if (nib < 4'd10) begin
			return ASCII_ZERO + {4'h0, nib};
		end
		return ASCII_UPPER_A + {4'h0, nib - 4'd10};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Snapshot of the step
	////////////////////////////////////////////////////////////////////////////

	// Held for the whole record, whatever the CPU does next
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			snap <= '0;
		end else if (step) begin
			snap <= trace;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Word formatting
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (fld)
			FLD_INSTR: field = snap.instr;
			FLD_ADDR:  field = snap.addr;
			FLD_DATA:  field = snap.wdata;
			default:   field = '0;
		endcase
	end

	always_comb begin
		if (fld == FLD_TAIL) begin
			// Five spaces, write flag, CR, LF
			for (int i = 0; i < CHARS_PER_WORD; i++) begin
				word.chars[i] = ASCII_SPACE;
			end
			word.chars[2] = ASCII_ZERO + {7'd0, snap.wr};
			word.chars[1] = ASCII_CR;
			word.chars[0] = ASCII_LF;
		end else begin
			// Top character holds the top nibble
			for (int i = 0; i < CHARS_PER_WORD; i++) begin
				word.chars[i] = hex_char(field[4*i +: 4]);
			end
		end
	end

endmodule

/* trace_pkg.sv */
package trace_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes and timing
	////////////////////////////////////////////////////////////////////////////

	// Clock cycles per serial bit, kept short for simulation
	localparam int BAUD_DIV = 16;
	localparam int BAUD_W = $clog2(BAUD_DIV);

	// Start bit, eight data bits, stop bit
	localparam int FRAME_BITS = 10;
	localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

	// One record is four words
	localparam int FIFO_WORDS = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_WORDS);

	localparam int CHARS_PER_WORD = 8;
	localparam int CHAR_IDX_W = $clog2(CHARS_PER_WORD);
	localparam int WORD_BITS = CHARS_PER_WORD * 8;

	////////////////////////////////////////////////////////////////////////////
	// ASCII codes
	////////////////////////////////////////////////////////////////////////////

	localparam logic [7:0] ASCII_CR = 8'h0d;
	localparam logic [7:0] ASCII_LF = 8'h0a;
	localparam logic [7:0] ASCII_SPACE = 8'h20;
	localparam logic [7:0] ASCII_ZERO = 8'h30;
	localparam logic [7:0] ASCII_UPPER_A = 8'h41;

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	// What the CPU shows for one step
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        wr;
	} cpu_trace_t;

	// One FIFO word, built as characters and stored flat
	typedef union packed {
		logic [CHARS_PER_WORD-1:0][7:0] chars;
		logic [WORD_BITS-1:0]           flat;
	} rec_word_u;

	// Which word of the record is being written
	typedef enum logic [1:0] {
		FLD_INSTR,
		FLD_ADDR,
		FLD_DATA,
		FLD_TAIL
	} rec_field_e;

	// Controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_INSTR,
		ST_ADDR,
		ST_DATA,
		ST_TAIL
	} trace_state_e;

endpackage

/* uart_tx.sv */
`timescale 1ns/10ps

module uart_tx import trace_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       trmt,
	input  logic [7:0] tx_byte,
	output logic       tbr,
	output logic       txd
);

	logic [FRAME_BITS-1:0] shift;
	logic [BAUD_W-1:0] baud_cnt;
	logic [FRAME_CNT_W-1:0] bit_cnt;
	logic busy;

	// Line sits on bit 0 of the shifter, ones fill in behind it
	assign txd = shift[0];
	assign tbr = ~busy;

	////////////////////////////////////////////////////////////////////////////
	// Frame shifter
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			shift <= '1;
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else if (trmt && !busy) begin
			// Stop bit, data LSB first, start bit
			shift <= {1'b1, tx_byte, 1'b0};
			busy <= 1'b1;
			baud_cnt <= '0;
			bit_cnt <= '0;
		end else if (busy) begin
			if (baud_cnt == BAUD_W'(BAUD_DIV - 1)) begin
				baud_cnt <= '0;
				shift <= {1'b1, shift[FRAME_BITS-1:1]};
				if (bit_cnt == FRAME_CNT_W'(FRAME_BITS - 1)) begin
					// Stop bit has run its full time
					busy <= 1'b0;
					bit_cnt <= '0;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

endmodule
